// File: list.f
+incdir+hw
hw/rv_exec_pkg.sv
hw/rv_alu.sv
hw/rv_decode.sv
hw/rv_execute.sv
hw/rv_result.sv
hw/rv_exec_top.sv
verification/tb_rv_exec.sv

// File: run_sim.sh
#!/bin/sh
# build and run the execute path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f list.f --top-module tb_rv_exec -o tb_rv_exec
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_rv_exec > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "^Simulation passed$" "$LOG"; then
  exit 0
fi
echo "pass message not found in $LOG"
exit 1

// File: verification/tb_rv_exec.sv
// rv64im execute path testbench
`timescale 1ns/1ps

module tb_rv_exec import rv_exec_pkg::*; ();

  logic        i_clk;
  logic        i_arst_n;
  logic        i_valid;
  issue_t      i_issue;
  logic        o_valid;
  wb_t         o_wb;
  logic [31:0] lfsr = 32'h8f7a_30c0;
  int          mismatch_errs = 0;
  int          other_errs = 0;

  // r-type ops as {funct7, funct3}
  logic [9:0] r_ops [18] = '{
    10'b0000000_000, 10'b0100000_000, 10'b0000000_001, 10'b0000000_010,
    10'b0000000_011, 10'b0000000_100, 10'b0000000_101, 10'b0100000_101,
    10'b0000000_110, 10'b0000000_111, 10'b0000001_000, 10'b0000001_001,
    10'b0000001_010, 10'b0000001_011, 10'b0000001_100, 10'b0000001_101,
    10'b0000001_110, 10'b0000001_111};

  rv_exec_top dut0 (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_issue  (i_issue),
    .o_valid  (o_valid),
    .o_wb     (o_wb)
  );

  initial begin
    i_clk = 1'b0;
    forever #50 i_clk = ~i_clk;
  end

  // taps 32, 22, 2, 1
  function automatic logic lfsr_bit();
    logic fb;
    fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
    lfsr = {lfsr[30:0], fb};
    return fb;
  endfunction

  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    int    i;
    v = '0;
    for (i = 0; i < n; i++)
      v = {v[62:0], lfsr_bit()};
    return v;
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input logic [2:0] f3,
                                  input reg_idx_t rd, input logic [6:0] opc);
    return {f7, 5'd2, 5'd1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_i(input logic [11:0] imm, input logic [2:0] f3,
                                  input reg_idx_t rd, input logic [6:0] opc);
    return {imm, 5'd1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_b(input logic [12:0] imm, input logic [2:0] f3);
    return {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  function automatic inst_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, 7'b1101111};
  endfunction

  // architectural result of an op or op-32 instruction
  function automatic xlen_t ref_op(input logic [6:0] f7, input logic [2:0] f3,
                                   input logic word, input xlen_t a, input xlen_t b);
    logic [127:0] p;
    logic [31:0]  aw;
    logic [31:0]  bw;
    logic [31:0]  rw;
    xlen_t        r;
    aw = a[31:0];
    bw = b[31:0];
    rw = '0;
    r  = '0;
    p  = '0;
    if (word) begin
      case ({f7[0], f3})
        4'b0_000: rw = f7[5] ? aw - bw : aw + bw;
        4'b0_001: rw = aw << bw[4:0];
        4'b0_101: begin
          if (f7[5])
            rw = $signed(aw) >>> bw[4:0];
          else
            rw = aw >> bw[4:0];
        end
        4'b1_000: rw = aw * bw;
        4'b1_100, 4'b1_110: begin
          if (bw == 32'd0)
            rw = f3[1] ? aw : '1;
          else if (aw == 32'h8000_0000 && bw == 32'hffff_ffff)
            rw = f3[1] ? 32'd0 : aw;
          else if (f3[1])
            rw = $signed(aw) % $signed(bw);
          else
            rw = $signed(aw) / $signed(bw);
        end
        4'b1_101, 4'b1_111: begin
          if (bw == 32'd0)
            rw = f3[1] ? aw : '1;
          else if (f3[1])
            rw = aw % bw;
          else
            rw = aw / bw;
        end
        default: rw = '0;
      endcase
      r = {{32{rw[31]}}, rw};
    end else if (f7[0]) begin
      case (f3)
        3'd0: r = a * b;
        3'd1: p = 128'($signed(a)) * 128'($signed(b));
        3'd2: p = 128'($signed(a)) * 128'(b);
        3'd3: p = 128'(a) * 128'(b);
        3'd4, 3'd6: begin
          if (b == 64'd0)
            r = f3[1] ? a : '1;
          else if (a == 64'h8000_0000_0000_0000 && b == 64'hffff_ffff_ffff_ffff)
            r = f3[1] ? 64'd0 : a;
          else if (f3[1])
            r = $signed(a) % $signed(b);
          else
            r = $signed(a) / $signed(b);
        end
        default: begin
          if (b == 64'd0)
            r = f3[1] ? a : '1;
          else if (f3[1])
            r = a % b;
          else
            r = a / b;
        end
      endcase
      // high product halves
      if (f3 inside {3'd1, 3'd2, 3'd3})
        r = p[127:64];
    end else begin
      case (f3)
        3'd0: r = f7[5] ? a - b : a + b;
        3'd1: r = a << b[5:0];
        3'd2: r = {63'b0, $signed(a) < $signed(b)};
        3'd3: r = {63'b0, a < b};
        3'd4: r = a ^ b;
        3'd5: begin
          if (f7[5])
            r = $signed(a) >>> b[5:0];
          else
            r = a >> b[5:0];
        end
        3'd6: r = a | b;
        default: r = a & b;
      endcase
    end
    return r;
  endfunction

  function automatic wb_t make_wb(input reg_idx_t rd, input xlen_t wdata, input logic wen,
                                  input xlen_t nextpc, input logic eb, input logic ill);
    wb_t w;
    w         = '0;
    w.rd      = rd;
    w.wdata   = wdata;
    w.wen     = wen;
    w.nextpc  = nextpc;
    w.ebreak  = eb;
    w.illegal = ill;
    return w;
  endfunction

  task automatic check_xlen(input string name, input string field,
                            input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %h actual %h", name, field, exp, act);
      mismatch_errs++;
    end
  endtask

  task automatic check_reg(input string name, input reg_idx_t exp, input reg_idx_t act);
    if (exp !== act) begin
      $display("mismatch %s rd expected %0d actual %0d", name, exp, act);
      mismatch_errs++;
    end
  endtask

  task automatic check_flag(input string name, input string field,
                            input logic exp, input logic act);
    if (exp !== act) begin
      $display("mismatch %s %s expected %b actual %b", name, field, exp, act);
      mismatch_errs++;
    end
  endtask

  // rd and wdata only matter when a write happens
  task automatic check_wb(input string name, input wb_t exp, input wb_t act);
    check_flag(name, "wen", exp.wen, act.wen);
    check_xlen(name, "nextpc", exp.nextpc, act.nextpc);
    check_flag(name, "ebreak", exp.ebreak, act.ebreak);
    check_flag(name, "illegal", exp.illegal, act.illegal);
    if (exp.wen) begin
      check_reg(name, exp.rd, act.rd);
      check_xlen(name, "wdata", exp.wdata, act.wdata);
    end
  endtask

  task automatic drive_issue(input inst_t inst, input xlen_t pc, input xlen_t a,
                             input xlen_t b);
    i_valid         = 1'b1;
    i_issue.inst    = inst;
    i_issue.pc      = pc;
    i_issue.rs1_val = a;
    i_issue.rs2_val = b;
  endtask

  task automatic issue_check(input string name, input inst_t inst, input xlen_t pc,
                             input xlen_t a, input xlen_t b, input wb_t exp);
    int waited;
    @(negedge i_clk);
    drive_issue(inst, pc, a, b);
    @(negedge i_clk);
    i_valid = 1'b0;
    waited  = 1;
    while (!o_valid && waited < 10) begin
      @(negedge i_clk);
      waited++;
    end
    if (!o_valid) begin
      $display("timeout waiting for o_valid in %s", name);
      other_errs++;
    end else begin
      check_wb(name, exp, o_wb);
    end
  endtask

  task automatic run_alu(input inst_t inst, input logic word, input xlen_t a,
                         input xlen_t rs2, input xlen_t b);
    xlen_t      pc;
    xlen_t      opb;
    logic [6:0] f7;
    wb_t        exp;
    pc  = rand_bits(40) & ~64'd3;
    // op-imm has no rs2 and no funct7 beyond the srai bit
    opb = inst[5] ? rs2 : b;
    f7  = inst[31:25];
    if (!inst[5])
      f7 = (inst[14:12] == 3'b101) ? {1'b0, inst[30], 5'b0} : 7'b0;
    exp = make_wb(inst[11:7], ref_op(f7, inst[14:12], word, a, opb),
                  inst[11:7] != 5'd0, pc + 64'd4, 1'b0, 1'b0);
    issue_check($sformatf("alu inst %h", inst), inst, pc, a, rs2, exp);
  endtask

  task automatic test_alu_ops();
    logic [2:0]  i_f3s [9];
    logic [5:0]  i_f6s [9];
    logic [11:0] imm;
    inst_t       inst;
    int          i;
    i_f3s = '{3'd0, 3'd2, 3'd3, 3'd4, 3'd6, 3'd7, 3'd1, 3'd5, 3'd5};
    i_f6s = '{6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'd0, 6'b010000};
    for (i = 0; i < 18; i++) begin
      inst = enc_r(r_ops[i][9:3], r_ops[i][2:0], reg_idx_t'(rand_bits(5)), 7'b0110011);
      run_alu(inst, 1'b0, rand_bits(64), rand_bits(64), 64'd0);
      run_alu(inst, 1'b0, rand_bits(64), rand_bits(12), 64'd0);
      run_alu(inst, 1'b0, rand_bits(20), rand_bits(64), 64'd0);
      // zero divisor and signed overflow
      if (r_ops[i][3] && r_ops[i][2]) begin
        run_alu(inst, 1'b0, rand_bits(64), 64'd0, 64'd0);
        run_alu(inst, 1'b0, 64'h8000_0000_0000_0000, 64'hffff_ffff_ffff_ffff, 64'd0);
      end
    end
    for (i = 0; i < 9; i++) begin
      imm = 12'(rand_bits(12));
      if (i_f3s[i] inside {3'd1, 3'd5})
        imm = {i_f6s[i], imm[5:0]};
      inst = enc_i(imm, i_f3s[i], reg_idx_t'(rand_bits(5)), 7'b0010011);
      run_alu(inst, 1'b0, rand_bits(64), rand_bits(64), {{52{imm[11]}}, imm});
    end
  endtask

  task automatic test_word_ops();
    logic [9:0] w_ops [10];
    inst_t      inst;
    int         i;
    w_ops = '{10'b0000000_000, 10'b0100000_000, 10'b0000000_001, 10'b0000000_101,
              10'b0100000_101, 10'b0000001_000, 10'b0000001_100, 10'b0000001_110,
              10'b0000001_101, 10'b0000001_111};
    for (i = 0; i < 10; i++) begin
      inst = enc_r(w_ops[i][9:3], w_ops[i][2:0], reg_idx_t'(rand_bits(5)), 7'b0111011);
      run_alu(inst, 1'b1, rand_bits(64), rand_bits(64), 64'd0);
      run_alu(inst, 1'b1, rand_bits(64), rand_bits(40), 64'd0);
      if (w_ops[i][3]) begin
        run_alu(inst, 1'b1, rand_bits(64), rand_bits(32) << 32, 64'd0);
        run_alu(inst, 1'b1, (rand_bits(32) << 32) | 64'h8000_0000,
                (rand_bits(32) << 32) | 64'hffff_ffff, 64'd0);
      end
    end
  endtask

  task automatic test_branches();
    logic [2:0]  f3s [6];
    xlen_t       as [5];
    xlen_t       bs [5];
    logic [12:0] imm;
    xlen_t       pc;
    logic        taken;
    int          i;
    int          j;
    f3s = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
    as  = '{rand_bits(64), 64'd5, 64'd9, 64'hffff_ffff_ffff_fffd, 64'd7};
    bs  = '{as[0], 64'd9, 64'd5, 64'd7, 64'hffff_ffff_ffff_fffd};
    for (i = 0; i < 6; i++) begin
      for (j = 0; j < 5; j++) begin
        imm = {12'(rand_bits(12)), 1'b0};
        pc  = rand_bits(40) & ~64'd3;
        case (f3s[i])
          3'd0: taken = (as[j] == bs[j]);
          3'd1: taken = (as[j] != bs[j]);
          3'd4: taken = ($signed(as[j]) < $signed(bs[j]));
          3'd5: taken = ($signed(as[j]) >= $signed(bs[j]));
          3'd6: taken = (as[j] < bs[j]);
          default: taken = (as[j] >= bs[j]);
        endcase
        issue_check($sformatf("branch f3 %0d case %0d", f3s[i], j), enc_b(imm, f3s[i]),
                    pc, as[j], bs[j],
                    make_wb('0, '0, 1'b0,
                            taken ? pc + {{51{imm[12]}}, imm} : pc + 64'd4, 1'b0, 1'b0));
      end
    end
  endtask

  task automatic test_jumps_upper();
    logic [20:0] jimm;
    logic [11:0] iimm;
    logic [19:0] uimm;
    xlen_t       pc;
    xlen_t       a;
    xlen_t       sum;
    pc   = rand_bits(40) & ~64'd3;
    jimm = {20'(rand_bits(20)), 1'b0};
    issue_check("jal", enc_j(jimm, 5'd5), pc, rand_bits(64), rand_bits(64),
                make_wb(5'd5, pc + 64'd4, 1'b1, pc + {{43{jimm[20]}}, jimm}, 1'b0, 1'b0));
    issue_check("jal x0", enc_j(jimm, 5'd0), pc, rand_bits(64), rand_bits(64),
                make_wb(5'd0, pc + 64'd4, 1'b0, pc + {{43{jimm[20]}}, jimm}, 1'b0, 1'b0));
    // force an odd target sum
    iimm = 12'(rand_bits(12));
    a    = rand_bits(64);
    sum  = a + {{52{iimm[11]}}, iimm};
    if (!sum[0]) begin
      a   = a ^ 64'd1;
      sum = a + {{52{iimm[11]}}, iimm};
    end
    issue_check("jalr", enc_i(iimm, 3'b000, 5'd7, 7'b1100111), pc, a, rand_bits(64),
                make_wb(5'd7, pc + 64'd4, 1'b1, sum & ~64'd1, 1'b0, 1'b0));
    uimm = 20'(rand_bits(20));
    issue_check("lui", {uimm, 5'd3, 7'b0110111}, pc, rand_bits(64), rand_bits(64),
                make_wb(5'd3, {{32{uimm[19]}}, uimm, 12'b0}, 1'b1, pc + 64'd4, 1'b0, 1'b0));
    issue_check("auipc", {uimm, 5'd4, 7'b0010111}, pc, rand_bits(64), rand_bits(64),
                make_wb(5'd4, pc + {{32{uimm[19]}}, uimm, 12'b0}, 1'b1, pc + 64'd4,
                        1'b0, 1'b0));
    issue_check("addi x0", enc_i(12'h123, 3'b000, 5'd0, 7'b0010011), pc, rand_bits(64),
                rand_bits(64), make_wb(5'd0, '0, 1'b0, pc + 64'd4, 1'b0, 1'b0));
  endtask

  task automatic test_traps();
    xlen_t pc;
    pc = rand_bits(40) & ~64'd3;
    issue_check("ebreak", 32'h0010_0073, pc, rand_bits(64), rand_bits(64),
                make_wb('0, '0, 1'b0, pc, 1'b1, 1'b0));
    issue_check("load", enc_i(12'h010, 3'b010, 5'd5, 7'b0000011), pc, rand_bits(64),
                rand_bits(64), make_wb('0, '0, 1'b0, pc, 1'b0, 1'b1));
  endtask

  // back to back strobes, results due exactly 3 cycles later
  task automatic test_stream();
    inst_t insts [20];
    xlen_t pcs [20];
    xlen_t as [20];
    xlen_t bs [20];
    wb_t   exps [20];
    int    k;
    int    c;
    for (k = 0; k < 20; k++) begin
      c        = int'(rand_bits(5) % 64'd18);
      insts[k] = enc_r(r_ops[c][9:3], r_ops[c][2:0], reg_idx_t'(rand_bits(5)), 7'b0110011);
      pcs[k]   = rand_bits(40) & ~64'd3;
      as[k]    = rand_bits(64);
      bs[k]    = rand_bits(64);
      exps[k]  = make_wb(insts[k][11:7],
                         ref_op(r_ops[c][9:3], r_ops[c][2:0], 1'b0, as[k], bs[k]),
                         insts[k][11:7] != 5'd0, pcs[k] + 64'd4, 1'b0, 1'b0);
    end
    for (c = 0; c < 27; c++) begin
      @(negedge i_clk);
      if (c >= 3 && c < 23) begin
        if (!o_valid) begin
          $display("no o_valid for stream instruction %0d", c - 3);
          other_errs++;
        end else begin
          check_wb($sformatf("stream %0d", c - 3), exps[c - 3], o_wb);
        end
      end else if (o_valid) begin
        $display("o_valid without a matching strobe at stream cycle %0d", c);
        other_errs++;
      end
      if (c < 20)
        drive_issue(insts[c], pcs[c], as[c], bs[c]);
      else
        i_valid = 1'b0;
    end
  endtask

  initial begin
    i_arst_n = 1'b0;
    i_valid  = 1'b0;
    i_issue  = '0;
    repeat (2) @(posedge i_clk);
    @(negedge i_clk);
    i_arst_n = 1'b1;
    test_alu_ops();
    test_word_ops();
    test_branches();
    test_jumps_upper();
    test_traps();
    test_stream();
    $display("errors: %0d mismatches, %0d other", mismatch_errs, other_errs);
    if (mismatch_errs == 0 && other_errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// File: hw/rv_exec_top.sv
// rv64im execute path top
`timescale 1ns/1ps

module rv_exec_top import rv_exec_pkg::*; (
  input  logic   i_clk,
  input  logic   i_arst_n,
  input  logic   i_valid,
  input  issue_t i_issue,
  output logic   o_valid,
  output wb_t    o_wb
);

  logic dec_valid;
  dec_t dec;
  logic exe_valid;
  exe_t exe;

  rv_decode u_decode (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (i_valid),
    .i_issue  (i_issue),
    .o_valid  (dec_valid),
    .o_dec    (dec)
  );

  rv_execute u_execute (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (dec_valid),
    .i_dec    (dec),
    .o_valid  (exe_valid),
    .o_exe    (exe)
  );

  rv_result u_result (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_valid  (exe_valid),
    .i_exe    (exe),
    .o_valid  (o_valid),
    .o_wb     (o_wb)
  );

endmodule

// File: hw/rv_result.sv
// rv64im result stage
`timescale 1ns/1ps

module rv_result import rv_exec_pkg::*; (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_valid,
  input  exe_t i_exe,
  output logic o_valid,
  output wb_t  o_wb
);

  logic trap;
  wb_t  wb_next;

  assign trap = i_exe.ebreak || i_exe.illegal;

  always_comb begin
    wb_next         = '0;
    wb_next.rd      = i_exe.rd;
    wb_next.wdata   = i_exe.is_jump ? i_exe.link : i_exe.alu_res;
    wb_next.wen     = i_exe.wen && !trap && (i_exe.rd != 5'd0);
    // link is pc + 4, so a trap steps back one word to its own pc
    wb_next.nextpc  = trap ? i_exe.link - 64'd4 : i_exe.taken_pc;
    wb_next.ebreak  = i_exe.ebreak;
    wb_next.illegal = i_exe.illegal;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_wb    <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_wb <= wb_next;
      end
    end
  end

  a_no_x0_write: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid |-> !(o_wb.wen && o_wb.rd == 5'd0));

endmodule

// File: hw/rv_execute.sv
// rv64im execute stage
`timescale 1ns/1ps

module rv_execute import rv_exec_pkg::*; (
  input  logic i_clk,
  input  logic i_arst_n,
  input  logic i_valid,
  input  dec_t i_dec,
  output logic o_valid,
  output exe_t o_exe
);

  xlen_t op_a;
  xlen_t op_b;
  xlen_t alu_res;
  xlen_t target;
  xlen_t pc_plus4;
  logic  eq;
  logic  lt;
  logic  ltu;
  logic  taken;
  exe_t  exe_next;

  assign op_a = i_dec.a_is_pc ? i_dec.pc : i_dec.rs1_val;
  assign op_b = i_dec.b_is_imm ? i_dec.imm : i_dec.rs2_val;

  rv_alu u_alu (
    .i_op   (i_dec.alu_op),
    .i_word (i_dec.word),
    .i_a    (op_a),
    .i_b    (op_b),
    .o_res  (alu_res)
  );

  // branches compare the registers directly
  assign eq  = (i_dec.rs1_val == i_dec.rs2_val);
  assign lt  = ($signed(i_dec.rs1_val) < $signed(i_dec.rs2_val));
  assign ltu = (i_dec.rs1_val < i_dec.rs2_val);

  always_comb begin
    case (i_dec.br_op)
      BR_JAL, BR_JALR: taken = 1'b1;
      BR_EQ:           taken = eq;
      BR_NE:           taken = !eq;
      BR_LT:           taken = lt;
      BR_GE:           taken = !lt;
      BR_LTU:          taken = ltu;
      BR_GEU:          taken = !ltu;
      default:         taken = 1'b0;
    endcase
  end

  // jalr target drops bit 0
  assign target   = (i_dec.br_op == BR_JALR)
                  ? ((i_dec.rs1_val + i_dec.imm) & ~64'd1)
                  : i_dec.pc + i_dec.imm;
  assign pc_plus4 = i_dec.pc + 64'd4;

  always_comb begin
    exe_next          = '0;
    exe_next.alu_res  = alu_res;
    exe_next.link     = pc_plus4;
    exe_next.taken_pc = taken ? target : pc_plus4;
    exe_next.rd       = i_dec.rd;
    exe_next.wen      = i_dec.wen;
    exe_next.is_jump  = (i_dec.br_op == BR_JAL) || (i_dec.br_op == BR_JALR);
    exe_next.ebreak   = i_dec.ebreak;
    exe_next.illegal  = i_dec.illegal;
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_exe   <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_exe <= exe_next;
      end
    end
  end

endmodule

// File: hw/rv_decode.sv
// rv64im decode stage
`timescale 1ns/1ps

module rv_decode import rv_exec_pkg::*; (
  input  logic   i_clk,
  input  logic   i_arst_n,
  input  logic   i_valid,
  input  issue_t i_issue,
  output logic   o_valid,
  output dec_t   o_dec
);

  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;
  localparam logic [6:0] OPC_JAL       = 7'b1101111;
  localparam logic [6:0] OPC_JALR      = 7'b1100111;
  localparam logic [6:0] OPC_BRANCH    = 7'b1100011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_SYSTEM    = 7'b1110011;
  localparam inst_t      INST_EBREAK   = 32'h0010_0073;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [5:0] funct6;
  xlen_t      imm_i;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  logic       writes_rd;
  logic       bad;
  dec_t       dec_next;

  assign opcode = i_issue.inst[6:0];
  assign funct3 = i_issue.inst[14:12];
  assign funct7 = i_issue.inst[31:25];
  assign funct6 = i_issue.inst[31:26];

  // immediates by format
  assign imm_i = {{52{i_issue.inst[31]}}, i_issue.inst[31:20]};
  assign imm_b = {{51{i_issue.inst[31]}}, i_issue.inst[31], i_issue.inst[7],
                  i_issue.inst[30:25], i_issue.inst[11:8], 1'b0};
  assign imm_u = {{32{i_issue.inst[31]}}, i_issue.inst[31:12], 12'b0};
  assign imm_j = {{43{i_issue.inst[31]}}, i_issue.inst[31], i_issue.inst[19:12],
                  i_issue.inst[20], i_issue.inst[30:21], 1'b0};

  always_comb begin
    dec_next         = '0;
    dec_next.alu_op  = ALU_ADD;
    dec_next.br_op   = BR_NONE;
    dec_next.pc      = i_issue.pc;
    dec_next.rs1_val = i_issue.rs1_val;
    dec_next.rs2_val = i_issue.rs2_val;
    dec_next.rd      = i_issue.inst[11:7];
    writes_rd        = 1'b0;
    bad              = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dec_next.alu_op   = ALU_COPY_B;
        dec_next.b_is_imm = 1'b1;
        dec_next.imm      = imm_u;
        writes_rd         = 1'b1;
      end
      OPC_AUIPC: begin
        dec_next.a_is_pc  = 1'b1;
        dec_next.b_is_imm = 1'b1;
        dec_next.imm      = imm_u;
        writes_rd         = 1'b1;
      end
      OPC_JAL: begin
        dec_next.br_op = BR_JAL;
        dec_next.imm   = imm_j;
        writes_rd      = 1'b1;
      end
      OPC_JALR: begin
        dec_next.br_op = BR_JALR;
        dec_next.imm   = imm_i;
        writes_rd      = 1'b1;
        bad            = (funct3 != 3'b000);
      end
      OPC_BRANCH: begin
        dec_next.imm = imm_b;
        case (funct3)
          3'b000:  dec_next.br_op = BR_EQ;
          3'b001:  dec_next.br_op = BR_NE;
          3'b100:  dec_next.br_op = BR_LT;
          3'b101:  dec_next.br_op = BR_GE;
          3'b110:  dec_next.br_op = BR_LTU;
          3'b111:  dec_next.br_op = BR_GEU;
          default: bad = 1'b1;
        endcase
      end
      OPC_OP_IMM: begin
        dec_next.b_is_imm = 1'b1;
        dec_next.imm      = imm_i;
        writes_rd         = 1'b1;
        case (funct3)
          3'b000: dec_next.alu_op = ALU_ADD;
          3'b010: dec_next.alu_op = ALU_SLT;
          3'b011: dec_next.alu_op = ALU_SLTU;
          3'b100: dec_next.alu_op = ALU_XOR;
          3'b110: dec_next.alu_op = ALU_OR;
          3'b111: dec_next.alu_op = ALU_AND;
          3'b001: begin
            dec_next.alu_op = ALU_SLL;
            bad             = (funct6 != 6'b000000);
          end
          default: begin
            dec_next.alu_op = funct6[4] ? ALU_SRA : ALU_SRL;
            bad             = ({funct6[5], funct6[3:0]} != 5'b0);
          end
        endcase
      end
      OPC_OP, OPC_OP_32: begin
        dec_next.word = (opcode == OPC_OP_32);
        writes_rd     = 1'b1;
        case ({funct7, funct3})
          10'b0000000_000: dec_next.alu_op = ALU_ADD;
          10'b0100000_000: dec_next.alu_op = ALU_SUB;
          10'b0000000_001: dec_next.alu_op = ALU_SLL;
          10'b0000000_101: dec_next.alu_op = ALU_SRL;
          10'b0100000_101: dec_next.alu_op = ALU_SRA;
          10'b0000001_000: dec_next.alu_op = ALU_MUL;
          10'b0000001_100: dec_next.alu_op = ALU_DIV;
          10'b0000001_101: dec_next.alu_op = ALU_DIVU;
          10'b0000001_110: dec_next.alu_op = ALU_REM;
          10'b0000001_111: dec_next.alu_op = ALU_REMU;
          10'b0000000_010: dec_next.alu_op = ALU_SLT;
          10'b0000000_011: dec_next.alu_op = ALU_SLTU;
          10'b0000000_100: dec_next.alu_op = ALU_XOR;
          10'b0000000_110: dec_next.alu_op = ALU_OR;
          10'b0000000_111: dec_next.alu_op = ALU_AND;
          10'b0000001_001: dec_next.alu_op = ALU_MULH;
          10'b0000001_010: dec_next.alu_op = ALU_MULHSU;
          10'b0000001_011: dec_next.alu_op = ALU_MULHU;
          default:         bad = 1'b1;
        endcase
        // op-32 has only add, sub, shifts, mul, div and rem
        if (dec_next.word && (funct3 inside {3'b010, 3'b011}
            || (funct3 inside {3'b100, 3'b110, 3'b111} && funct7 != 7'b0000001)
            || (funct3 == 3'b001 && funct7 == 7'b0000001))) begin
          bad = 1'b1;
        end
      end
      OPC_OP_IMM_32: begin
        dec_next.word     = 1'b1;
        dec_next.b_is_imm = 1'b1;
        dec_next.imm      = imm_i;
        writes_rd         = 1'b1;
        case ({funct7, funct3}) inside
          10'b???????_000: dec_next.alu_op = ALU_ADD;
          10'b0000000_001: dec_next.alu_op = ALU_SLL;
          10'b0000000_101: dec_next.alu_op = ALU_SRL;
          10'b0100000_101: dec_next.alu_op = ALU_SRA;
          default:         bad = 1'b1;
        endcase
      end
      OPC_SYSTEM: begin
        dec_next.ebreak = (i_issue.inst == INST_EBREAK);
        bad             = (i_issue.inst != INST_EBREAK);
      end
      default: bad = 1'b1;
    endcase
    dec_next.illegal = bad;
    dec_next.wen     = writes_rd && !bad && (dec_next.rd != 5'd0);
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_valid <= 1'b0;
      o_dec   <= '0;
    end else begin
      o_valid <= i_valid;
      if (i_valid) begin
        o_dec <= dec_next;
      end
    end
  end

  a_trap_onehot: assert property (@(posedge i_clk) disable iff (!i_arst_n)
    o_valid |-> !(o_dec.ebreak && o_dec.illegal));

endmodule

// File: hw/rv_alu.sv
// rv64im integer alu
`timescale 1ns/1ps
`include "rv_exec_cfg.svh"

module rv_alu import rv_exec_pkg::*; (
  input  alu_op_t i_op,
  input  logic    i_word,
  input  xlen_t   i_a,
  input  xlen_t   i_b,
  output xlen_t   o_res
);

  xlen_t                  a;
  xlen_t                  b;
  xlen_t                  sum;
  xlen_t                  diff;
  logic                   carry;
  logic                   ovf;
  logic [`RV_SHAMT_W-1:0] shamt;
  xlen_t                  sra_src;
  logic [2*`RV_XLEN-1:0]  prod_ss;
  logic [2*`RV_XLEN-1:0]  prod_su;
  logic [2*`RV_XLEN-1:0]  prod_uu;
  xlen_t                  sa;
  xlen_t                  sb;
  xlen_t                  div_b;
  logic                   div_zero;
  logic                   div_ovf;
  xlen_t                  quo_s;
  xlen_t                  rem_s;
  xlen_t                  raw;

  // word mode works on the low half only
  assign a = i_word ? {32'b0, i_a[31:0]} : i_a;
  assign b = i_word ? {32'b0, i_b[31:0]} : i_b;

  assign sum            = a + b;
  assign {carry, diff}  = {1'b0, a} + {1'b0, ~b} + 65'd1;
  assign ovf            = (a[63] ^ b[63]) & (a[63] ^ diff[63]);

  assign shamt   = i_word ? {1'b0, b[4:0]} : b[`RV_SHAMT_W-1:0];
  // sraw fills from bit 31
  assign sra_src = i_word ? {{32{a[31]}}, a[31:0]} : a;

  assign prod_ss = {{64{a[63]}}, a} * {{64{b[63]}}, b};
  assign prod_su = {{64{a[63]}}, a} * {64'b0, b};
  assign prod_uu = {64'b0, a} * {64'b0, b};

  // signed view of the operands for div and rem
  assign sa = i_word ? {{32{a[31]}}, a[31:0]} : a;
  assign sb = i_word ? {{32{b[31]}}, b[31:0]} : b;

  assign div_zero = (b == '0);
  assign div_ovf  = i_word ? (a[31:0] == 32'h8000_0000 && b[31:0] == 32'hffff_ffff)
                           : (a == {1'b1, 63'b0} && b == '1);
  assign div_b    = (div_zero || div_ovf) ? 64'd1 : sb;

  assign quo_s = div_zero ? '1 : (div_ovf ? sa : xlen_t'($signed(sa) / $signed(div_b)));
  assign rem_s = div_zero ? sa : (div_ovf ? '0 : xlen_t'($signed(sa) % $signed(div_b)));

  always_comb begin
    case (i_op)
      ALU_ADD:    raw = sum;
      ALU_SUB:    raw = diff;
      ALU_SLT:    raw = {63'b0, diff[63] ^ ovf};
      ALU_SLTU:   raw = {63'b0, ~carry};
      ALU_XOR:    raw = a ^ b;
      ALU_OR:     raw = a | b;
      ALU_AND:    raw = a & b;
      ALU_SLL:    raw = a << shamt;
      ALU_SRL:    raw = a >> shamt;
      ALU_SRA:    raw = xlen_t'($signed(sra_src) >>> shamt);
      ALU_MUL:    raw = prod_uu[63:0];
      ALU_MULH:   raw = prod_ss[127:64];
      ALU_MULHSU: raw = prod_su[127:64];
      ALU_MULHU:  raw = prod_uu[127:64];
      ALU_DIV:    raw = quo_s;
      ALU_DIVU:   raw = div_zero ? '1 : a / (div_zero ? 64'd1 : b);
      ALU_REM:    raw = rem_s;
      ALU_REMU:   raw = div_zero ? a : a % (div_zero ? 64'd1 : b);
      ALU_COPY_B: raw = b;
      default:    raw = '0;
    endcase
  end

  assign o_res = i_word ? {{32{raw[31]}}, raw[31:0]} : raw;

  always_comb begin
    a_op_known: assert (i_op <= ALU_COPY_B)
      else $error("alu op %0d outside the defined codes", i_op);
  end

endmodule

// File: hw/rv_exec_pkg.sv
// rv64im execute path types
`include "rv_exec_cfg.svh"

package rv_exec_pkg;

  typedef logic [`RV_XLEN-1:0]     xlen_t;
  typedef logic [`RV_ILEN-1:0]     inst_t;
  typedef logic [4:0]              reg_idx_t;
  typedef logic [`RV_ALU_OP_W-1:0] alu_op_t;
  // nine branch kinds, so four bits
  typedef logic [3:0]              br_op_t;

  localparam alu_op_t ALU_ADD    = 5'd0;
  localparam alu_op_t ALU_SUB    = 5'd1;
  localparam alu_op_t ALU_SLT    = 5'd2;
  localparam alu_op_t ALU_SLTU   = 5'd3;
  localparam alu_op_t ALU_XOR    = 5'd4;
  localparam alu_op_t ALU_OR     = 5'd5;
  localparam alu_op_t ALU_AND    = 5'd6;
  localparam alu_op_t ALU_SLL    = 5'd7;
  localparam alu_op_t ALU_SRL    = 5'd8;
  localparam alu_op_t ALU_SRA    = 5'd9;
  localparam alu_op_t ALU_MUL    = 5'd10;
  localparam alu_op_t ALU_MULH   = 5'd11;
  localparam alu_op_t ALU_MULHSU = 5'd12;
  localparam alu_op_t ALU_MULHU  = 5'd13;
  localparam alu_op_t ALU_DIV    = 5'd14;
  localparam alu_op_t ALU_DIVU   = 5'd15;
  localparam alu_op_t ALU_REM    = 5'd16;
  localparam alu_op_t ALU_REMU   = 5'd17;
  // lui passes operand b through
  localparam alu_op_t ALU_COPY_B = 5'd18;

  localparam br_op_t BR_NONE = 4'd0;
  localparam br_op_t BR_JAL  = 4'd1;
  localparam br_op_t BR_JALR = 4'd2;
  localparam br_op_t BR_EQ   = 4'd3;
  localparam br_op_t BR_NE   = 4'd4;
  localparam br_op_t BR_LT   = 4'd5;
  localparam br_op_t BR_GE   = 4'd6;
  localparam br_op_t BR_LTU  = 4'd7;
  localparam br_op_t BR_GEU  = 4'd8;

  typedef struct packed {
    inst_t inst;
    xlen_t pc;
    xlen_t rs1_val;
    xlen_t rs2_val;
  } issue_t;

  typedef struct packed {
    alu_op_t  alu_op;
    logic     a_is_pc;
    logic     b_is_imm;
    logic     word;
    br_op_t   br_op;
    xlen_t    imm;
    xlen_t    pc;
    xlen_t    rs1_val;
    xlen_t    rs2_val;
    reg_idx_t rd;
    logic     wen;
    logic     ebreak;
    logic     illegal;
  } dec_t;

  typedef struct packed {
    xlen_t    alu_res;
    xlen_t    link;
    xlen_t    taken_pc;
    reg_idx_t rd;
    logic     wen;
    logic     is_jump;
    logic     ebreak;
    logic     illegal;
  } exe_t;

  typedef struct packed {
    reg_idx_t rd;
    xlen_t    wdata;
    logic     wen;
    xlen_t    nextpc;
    logic     ebreak;
    logic     illegal;
  } wb_t;

endpackage

// File: hw/rv_exec_cfg.svh
// rv64im execute path config
`ifndef RV_EXEC_CFG_SVH
`define RV_EXEC_CFG_SVH

// instruction width
`define RV_ILEN 32

// data width
`define RV_XLEN 64

// shift amount, 6 bits for rv64
`define RV_SHAMT_W 6

// alu op code width
`define RV_ALU_OP_W 5

`endif
